// File: source/io_map_pkg.sv
// Board I/O address map
// Byte addresses of the memory-mapped registers on the processor I/O bus
// and the widths of the board indicator ports
package io_map_pkg;

	// Bus address and data width
	localparam int io_width = 32;

	// Indicator registers, one word apart
	localparam logic [io_width-1:0] addr_red_led = 32'h00;
	localparam logic [io_width-1:0] addr_green_led = 32'h04;
	localparam logic [io_width-1:0] addr_hex0 = 32'h08;
	localparam logic [io_width-1:0] addr_hex1 = 32'h0c;
	localparam logic [io_width-1:0] addr_hex2 = 32'h10;
	localparam logic [io_width-1:0] addr_hex3 = 32'h14;

	// UART block
	localparam logic [io_width-1:0] addr_uart_status = 32'h18;
	localparam logic [io_width-1:0] addr_uart_data = 32'h1c;

	// Free-running cycle counter, read only
	localparam logic [io_width-1:0] addr_timer = 32'h24;

	// Board indicators
	localparam int red_led_width = 18;	// LEDR
	localparam int green_led_width = 9;	// LEDG
	localparam int hex_width = 7;		// Raw segments, no decoder

endpackage

// File: source/uart_pkg.sv
// UART encoding and baud timing
// 8N1 framing at a fixed divide of clk50, plus the software view of
// the UART read word
package uart_pkg;

	localparam int baud_divide = 27;			// clk50 cycles per bit
	localparam int data_bits = 8;
	localparam int frame_bits = data_bits + 2;	// Start + data + stop

	// Counter sizes
	localparam int baud_count_width = $clog2(baud_divide);
	localparam int bit_count_width = $clog2(frame_bits + 1);

	// Counter reload values
	localparam logic [baud_count_width-1:0] baud_reload = baud_count_width'(baud_divide - 1);
	localparam logic [baud_count_width-1:0] half_reload = baud_count_width'(baud_divide / 2 - 1);
	localparam logic [bit_count_width-1:0] stop_index = bit_count_width'(frame_bits - 1);
	localparam logic [bit_count_width-1:0] tail_index = bit_count_width'(frame_bits);

	// Status word bits
	localparam int status_tx_ready = 0;
	localparam int status_rx_ready = 1;
	localparam int status_overrun = 2;

	// One read word, decoded per address
	typedef union packed {
		struct packed {
			logic [28:0] reserved;
			logic overrun;
			logic rx_ready;
			logic tx_ready;
		} status;
		struct packed {
			logic [23:0] reserved;
			logic [data_bits-1:0] rx_byte;
		} data;
	} uart_read_word;

endpackage

// File: source/uart_transmit.sv
// UART transmitter
// Sends one byte as an 8N1 frame, start bit low and LSB first,
// holding the line high between frames
module uart_transmit(
	input logic clk50,
	input logic core_reset,
	input logic tx_start,
	input logic [uart_pkg::data_bits-1:0] tx_byte,
	output logic tx_busy,
	output logic uart_tx);

	logic [uart_pkg::frame_bits-1:0] tx_shift;		// Stop, data, start
	logic [uart_pkg::baud_count_width-1:0] baud_count;
	logic [uart_pkg::bit_count_width-1:0] bit_count;	// Bits left after current

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			tx_busy <= 1'b0;
			tx_shift <= '1;		// Line idles high
			baud_count <= '0;
			bit_count <= '0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				// Load full frame, start bit goes out now
				tx_busy <= 1'b1;
				tx_shift <= {1'b1, tx_byte, 1'b0};
				baud_count <= uart_pkg::baud_reload;
				bit_count <= uart_pkg::stop_index;
			end
		end
		else if (baud_count != '0)
			baud_count <= baud_count - uart_pkg::baud_count_width'(1);
		else if (bit_count == '0)
		begin
			// End of stop bit
			tx_busy <= 1'b0;
		end
		else
		begin
			// Next bit, ones fill from the top
			tx_shift <= {1'b1, tx_shift[uart_pkg::frame_bits-1:1]};
			bit_count <= bit_count - uart_pkg::bit_count_width'(1);
			baud_count <= uart_pkg::baud_reload;
		end
	end

	// Stop bit stays in bit 0 after the frame
	assign uart_tx = tx_shift[0];

endmodule

// File: source/uart_receive.sv
// UART receiver
// Synchronizes the rx line, samples each bit at mid-period and
// delivers a byte only when the stop bit is high
module uart_receive(
	input logic clk50,
	input logic core_reset,
	input logic uart_rx,
	output logic rx_strobe,
	output logic [uart_pkg::data_bits-1:0] rx_byte);

	logic rx_meta;		// First sync stage
	logic rx_sync;		// Safe to use
	logic rx_last;		// For edge detect
	logic start_edge;
	logic sample_now;
	logic rx_active;
	logic stop_ok;
	logic [uart_pkg::baud_count_width-1:0] baud_count;
	logic [uart_pkg::bit_count_width-1:0] bit_index;	// 0 start, 1-8 data, 9 stop, 10 tail
	logic [uart_pkg::data_bits-1:0] rx_shift;

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end
		else
		begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	assign start_edge = rx_last && !rx_sync;	// High to low
	assign sample_now = baud_count == '0;

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_active <= 1'b0;
			rx_strobe <= 1'b0;
			stop_ok <= 1'b0;
			baud_count <= '0;
			bit_index <= '0;
		end
		else
		begin
			rx_strobe <= 1'b0;
			if (!rx_active)
			begin
				if (start_edge)
				begin
					rx_active <= 1'b1;
					baud_count <= uart_pkg::half_reload;	// Aim for start-bit centre
					bit_index <= '0;
				end
			end
			else if (bit_index == uart_pkg::tail_index)
			begin
				// Half a bit past stop centre, or cut short by the next start
				if (start_edge || sample_now)
				begin
					rx_strobe <= stop_ok;
					rx_active <= start_edge;
					baud_count <= uart_pkg::half_reload;
					bit_index <= '0;
				end
				else
					baud_count <= baud_count - uart_pkg::baud_count_width'(1);
			end
			else if (!sample_now)
				baud_count <= baud_count - uart_pkg::baud_count_width'(1);
			else if (bit_index == '0)
			begin
				if (rx_sync)
					rx_active <= 1'b0;	// Glitch, start bit gone
				else
				begin
					bit_index <= bit_index + uart_pkg::bit_count_width'(1);
					baud_count <= uart_pkg::baud_reload;
				end
			end
			else if (bit_index == uart_pkg::stop_index)
			begin
				stop_ok <= rx_sync;		// Low means framing error
				bit_index <= uart_pkg::tail_index;
				baud_count <= uart_pkg::half_reload;
			end
			else
			begin
				bit_index <= bit_index + uart_pkg::bit_count_width'(1);
				baud_count <= uart_pkg::baud_reload;
			end
		end
	end

	// Data bits, LSB first
	always_ff @(posedge clk50)
	begin
		if (rx_active && sample_now && bit_index != '0 && bit_index < uart_pkg::stop_index)
			rx_shift <= {rx_sync, rx_shift[uart_pkg::data_bits-1:1]};
	end

	assign rx_byte = rx_shift;

endmodule

// File: source/uart.sv
// UART register block
// Status and data words on the I/O bus, received byte holding with
// rx_ready and overrun, and transmit start on a data write
module uart(
	input logic clk50,
	input logic core_reset,
	input logic io_read_en,
	input logic io_write_en,
	input logic [io_map_pkg::io_width-1:0] io_address,
	input logic [io_map_pkg::io_width-1:0] io_write_data,
	output logic [io_map_pkg::io_width-1:0] uart_read_data,
	output logic uart_tx,
	input logic uart_rx);

	logic status_selected;
	logic data_selected;
	logic tx_start;
	logic tx_busy;
	logic rx_strobe;
	logic [uart_pkg::data_bits-1:0] rx_byte;
	logic [uart_pkg::data_bits-1:0] rx_data;	// Last byte received
	logic rx_ready;
	logic overrun;
	uart_pkg::uart_read_word read_word;

	assign status_selected = io_address == io_map_pkg::addr_uart_status;
	assign data_selected = io_address == io_map_pkg::addr_uart_data;

	// Writes while busy are dropped
	assign tx_start = io_write_en && data_selected && !tx_busy;

	uart_transmit uart_transmit(
		.clk50(clk50),
		.core_reset(core_reset),
		.tx_start(tx_start),
		.tx_byte(io_write_data[uart_pkg::data_bits-1:0]),
		.tx_busy(tx_busy),
		.uart_tx(uart_tx));

	uart_receive uart_receive(
		.clk50(clk50),
		.core_reset(core_reset),
		.uart_rx(uart_rx),
		.rx_strobe(rx_strobe),
		.rx_byte(rx_byte));

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			rx_ready <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			if (io_read_en && data_selected)
				rx_ready <= 1'b0;		// Byte consumed
			if (io_read_en && status_selected)
				overrun <= 1'b0;
			if (rx_strobe)
			begin
				rx_ready <= 1'b1;
				if (rx_ready && !(io_read_en && data_selected))
					overrun <= 1'b1;	// Unread byte lost
			end
		end
	end

	always_ff @(posedge clk50)
	begin
		if (rx_strobe)
			rx_data <= rx_byte;
	end

	always_comb
	begin
		read_word = '0;
		if (status_selected)
		begin
			read_word.status.tx_ready = !tx_busy;
			read_word.status.rx_ready = rx_ready;
			read_word.status.overrun = overrun;
		end
		else if (data_selected)
			read_word.data.rx_byte = rx_data;
	end

	assign uart_read_data = read_word;

	// Only a data read consumes the byte
	assert property (@(posedge clk50) disable iff (core_reset)
		$fell(rx_ready) |-> $past(io_read_en && data_selected))
		else $error("rx_ready cleared without a data read");

	// Transmitter takes every accepted start
	assert property (@(posedge clk50) disable iff (core_reset)
		tx_start |=> tx_busy)
		else $error("tx_start not taken by the transmitter");

endmodule

// File: source/io_registers.sv
// Board I/O registers
// LED and seven-segment registers written from the bus, a free-running
// cycle timer and the combinational read multiplexer
module io_registers(
	input logic clk50,
	input logic core_reset,
	input logic io_write_en,
	input logic [io_map_pkg::io_width-1:0] io_address,
	input logic [io_map_pkg::io_width-1:0] io_write_data,
	input logic [io_map_pkg::io_width-1:0] uart_read_data,
	output logic [io_map_pkg::io_width-1:0] io_read_data,
	output logic [io_map_pkg::red_led_width-1:0] red_led,
	output logic [io_map_pkg::green_led_width-1:0] green_led,
	output logic [io_map_pkg::hex_width-1:0] hex0,
	output logic [io_map_pkg::hex_width-1:0] hex1,
	output logic [io_map_pkg::hex_width-1:0] hex2,
	output logic [io_map_pkg::hex_width-1:0] hex3);

	logic [io_map_pkg::io_width-1:0] timer_value;

	always_ff @(posedge clk50, posedge core_reset)
	begin
		if (core_reset)
		begin
			red_led <= '0;
			green_led <= '0;
			hex0 <= '0;
			hex1 <= '0;
			hex2 <= '0;
			hex3 <= '0;
			timer_value <= '0;
		end
		else
		begin
			timer_value <= timer_value + io_map_pkg::io_width'(1);	// Wraps

			// Upper write bits dropped
			if (io_write_en)
			begin
				case (io_address)
					io_map_pkg::addr_red_led:
						red_led <= io_write_data[io_map_pkg::red_led_width-1:0];
					io_map_pkg::addr_green_led:
						green_led <= io_write_data[io_map_pkg::green_led_width-1:0];
					io_map_pkg::addr_hex0: hex0 <= io_write_data[io_map_pkg::hex_width-1:0];
					io_map_pkg::addr_hex1: hex1 <= io_write_data[io_map_pkg::hex_width-1:0];
					io_map_pkg::addr_hex2: hex2 <= io_write_data[io_map_pkg::hex_width-1:0];
					io_map_pkg::addr_hex3: hex3 <= io_write_data[io_map_pkg::hex_width-1:0];
					default: ;		// UART or unmapped
				endcase
			end
		end
	end

	// Same-cycle read, indicators are write only
	always_comb
	begin
		case (io_address)
			io_map_pkg::addr_uart_status,
			io_map_pkg::addr_uart_data:
				io_read_data = uart_read_data;
			io_map_pkg::addr_timer:
				io_read_data = timer_value;
			default:
				io_read_data = '0;
		endcase
	end

	// LEDs only move on a bus write
	assert property (@(posedge clk50) disable iff (core_reset)
		!$stable({red_led, green_led}) |-> $past(io_write_en))
		else $error("LED register changed without a write strobe");

endmodule

// File: source/fpga_io_top.sv
// FPGA board I/O top
// Connects the processor-side I/O bus to the indicator registers,
// the cycle timer and the UART
module fpga_io_top(
	input logic clk50,
	input logic core_reset,

	// Processor I/O bus
	input logic io_write_en,
	input logic io_read_en,
	input logic [io_map_pkg::io_width-1:0] io_address,
	input logic [io_map_pkg::io_width-1:0] io_write_data,
	output logic [io_map_pkg::io_width-1:0] io_read_data,

	// Indicators
	output logic [io_map_pkg::red_led_width-1:0] red_led,
	output logic [io_map_pkg::green_led_width-1:0] green_led,
	output logic [io_map_pkg::hex_width-1:0] hex0,
	output logic [io_map_pkg::hex_width-1:0] hex1,
	output logic [io_map_pkg::hex_width-1:0] hex2,
	output logic [io_map_pkg::hex_width-1:0] hex3,

	// Serial port
	output logic uart_tx,
	input logic uart_rx);

	logic [io_map_pkg::io_width-1:0] uart_read_data;	// UART word into read mux

	io_registers io_registers(
		.clk50(clk50),
		.core_reset(core_reset),
		.io_write_en(io_write_en),
		.io_address(io_address),
		.io_write_data(io_write_data),
		.uart_read_data(uart_read_data),
		.io_read_data(io_read_data),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3));

	// Decodes its own two addresses
	uart uart(
		.clk50(clk50),
		.core_reset(core_reset),
		.io_read_en(io_read_en),
		.io_write_en(io_write_en),
		.io_address(io_address),
		.io_write_data(io_write_data),
		.uart_read_data(uart_read_data),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx));

endmodule

// File: dv/tb_clock.sv
// Testbench clock source
// Free-running clk50 with a period of 4 time units
module tb_clock(
	output logic clk50);

	initial
	begin
		clk50 = 1'b0;
		forever #2 clk50 = ~clk50;	// Half period
	end

endmodule

// File: dv/io_tb.sv
// Board I/O testbench
// Plays the processor on the I/O bus, replays the golden operation list
// and checks read data, UART words and the indicator ports
module io_tb;

	logic clk50;
	logic core_reset;
	logic io_write_en;
	logic io_read_en;
	logic [io_map_pkg::io_width-1:0] io_address;
	logic [io_map_pkg::io_width-1:0] io_write_data;
	logic [io_map_pkg::io_width-1:0] io_read_data;
	logic [io_map_pkg::red_led_width-1:0] red_led;
	logic [io_map_pkg::green_led_width-1:0] green_led;
	logic [io_map_pkg::hex_width-1:0] hex0;
	logic [io_map_pkg::hex_width-1:0] hex1;
	logic [io_map_pkg::hex_width-1:0] hex2;
	logic [io_map_pkg::hex_width-1:0] hex3;
	logic uart_tx;
	logic uart_rx;
	logic direct_rx;	// Golden file owns the rx line
	logic rx_drive;
	logic aborted;		// Stops the replay after a timeout
	logic [io_map_pkg::io_width-1:0] expected_leds [0:5];	// Per indicator address
	int word_errors;
	int status_errors;
	int data_errors;
	int indicator_errors;
	int other_errors;

	tb_clock clock_gen(.clk50(clk50));

	// Loopback unless a bad frame is being driven
	assign uart_rx = direct_rx ? rx_drive : uart_tx;

	fpga_io_top dut(
		.clk50(clk50),
		.core_reset(core_reset),
		.io_write_en(io_write_en),
		.io_read_en(io_read_en),
		.io_address(io_address),
		.io_write_data(io_write_data),
		.io_read_data(io_read_data),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.uart_tx(uart_tx),
		.uart_rx(uart_rx));

	task automatic check_word(input string name,
		input logic [io_map_pkg::io_width-1:0] expected,
		input logic [io_map_pkg::io_width-1:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			word_errors++;
		end
	endtask

	task automatic check_status(input uart_pkg::uart_read_word expected,
		input uart_pkg::uart_read_word actual);
		if (actual.status !== expected.status)
		begin
			$display("[ERROR] io_read_data status expected %h actual %h", expected, actual);
			status_errors++;
		end
	endtask

	task automatic check_data(input uart_pkg::uart_read_word expected,
		input uart_pkg::uart_read_word actual);
		if (actual.data !== expected.data)
		begin
			$display("[ERROR] io_read_data data expected %h actual %h", expected, actual);
			data_errors++;
		end
	endtask

	task automatic compare_port(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			indicator_errors++;
		end
	endtask

	task automatic check_indicators();
		compare_port("red_led", expected_leds[0], 32'(red_led));
		compare_port("green_led", expected_leds[1], 32'(green_led));
		compare_port("hex0", expected_leds[2], 32'(hex0));
		compare_port("hex1", expected_leds[3], 32'(hex1));
		compare_port("hex2", expected_leds[4], 32'(hex2));
		compare_port("hex3", expected_leds[5], 32'(hex3));
		compare_port("uart_tx", 32'd1, 32'(uart_tx));	// Line idles high
	endtask

	// Bits a register keeps, the rest get random fill
	function automatic logic [io_map_pkg::io_width-1:0] write_mask(
		input logic [io_map_pkg::io_width-1:0] address);
		int width;
		case (address)
			io_map_pkg::addr_red_led: width = io_map_pkg::red_led_width;
			io_map_pkg::addr_green_led: width = io_map_pkg::green_led_width;
			io_map_pkg::addr_hex0,
			io_map_pkg::addr_hex1,
			io_map_pkg::addr_hex2,
			io_map_pkg::addr_hex3: width = io_map_pkg::hex_width;
			io_map_pkg::addr_uart_data: width = uart_pkg::data_bits;
			default: width = io_map_pkg::io_width;
		endcase
		write_mask = {io_map_pkg::io_width{1'b1}} >> (io_map_pkg::io_width - width);
	endfunction

	task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
		logic [31:0] mask;
		logic [31:0] noise;
		mask = write_mask(address);
		noise = $urandom;
		@(negedge clk50);
		io_address = address;
		io_write_data = (data & mask) | (noise & ~mask);
		io_write_en = 1'b1;
		@(negedge clk50);	// One rising edge with the strobe
		io_write_en = 1'b0;
	endtask

	task automatic read_expect(input logic [31:0] address, input logic [31:0] expected);
		logic [31:0] value;
		@(negedge clk50);
		io_address = address;
		io_read_en = 1'b1;	// Consumes rx byte or clears overrun
		#1;
		value = io_read_data;	// Same cycle, before the edge
		@(negedge clk50);
		io_read_en = 1'b0;
		if (address == io_map_pkg::addr_uart_status)
			check_status(expected, value);
		else if (address == io_map_pkg::addr_uart_data)
			check_data(expected, value);
		else
			check_word("io_read_data", expected, value);
	endtask

	// Poll status without a read strobe until masked bits match
	task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
		int cycles;
		cycles = 0;
		@(negedge clk50);
		io_address = io_map_pkg::addr_uart_status;
		#1;
		while ((io_read_data & mask) !== value
			&& cycles < 3 * uart_pkg::frame_bits * uart_pkg::baud_divide)	// Three frames
		begin
			@(negedge clk50);
			#1;
			cycles++;
		end
		if ((io_read_data & mask) !== value)
		begin
			$display("Timed out after %0d cycles waiting for UART status %h under mask %h",
				cycles, value, mask);
			other_errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic timer_delta(input logic [31:0] count, input logic [31:0] expected);
		logic [31:0] first;
		logic [31:0] second;
		@(negedge clk50);
		io_address = io_map_pkg::addr_timer;
		#1;
		first = io_read_data;
		repeat (count) @(negedge clk50);
		#1;
		second = io_read_data;
		check_word("timer delta", expected, second - first);
	endtask

	task automatic send_bad_frame(input logic [7:0] value);
		logic [uart_pkg::frame_bits-1:0] frame;
		int bit_pos;
		frame = {1'b0, value, 1'b0};	// Stop bit low
		@(negedge clk50);
		direct_rx = 1'b1;
		for (bit_pos = 0; bit_pos < uart_pkg::frame_bits; bit_pos++)
		begin
			rx_drive = frame[bit_pos];	// LSB first after start
			repeat (uart_pkg::baud_divide) @(negedge clk50);
		end
		rx_drive = 1'b1;
		repeat (2 * uart_pkg::baud_divide) @(negedge clk50);	// Past the receiver tail
		direct_rx = 1'b0;
	endtask

	// One golden line: op address data expected
	task automatic run_line(input string line);
		logic [7:0] op;
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] expected;
		int fields;
		fields = $sscanf(line, "%c %h %h %h", op, address, data, expected);
		if (fields != 4)
		begin
			$display("Golden line could not be parsed: %s", line);
			other_errors++;
		end
		else
		begin
			case (op)
				"W": bus_write(address, data);
				"R": read_expect(address, expected);
				"C":
				begin
					if (address <= io_map_pkg::addr_hex3)
						expected_leds[address[4:2]] = expected;
					check_indicators();
				end
				"X": wait_status(data, expected);
				"T": timer_delta(data, expected);
				"B": send_bad_frame(data[7:0]);
				default:
				begin
					$display("Unknown golden operation %c", op);
					other_errors++;
				end
			endcase
		end
	endtask

	initial
	begin
		int fd;
		string line;
		void'($urandom(32'h8e0a));	// Seed once
		core_reset = 1'b1;
		io_write_en = 1'b0;
		io_read_en = 1'b0;
		io_address = '0;
		io_write_data = '0;
		direct_rx = 1'b0;
		rx_drive = 1'b1;
		aborted = 1'b0;
		word_errors = 0;
		status_errors = 0;
		data_errors = 0;
		indicator_errors = 0;
		other_errors = 0;
		foreach (expected_leds[i])
			expected_leds[i] = '0;
		repeat (8) @(negedge clk50);
		core_reset = 1'b0;

		fd = $fopen("dv/io_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the golden file dv/io_golden.txt");
			other_errors++;
			aborted = 1'b1;
		end
		while (!aborted && $fgets(line, fd) > 0)
		begin
			if (line.len() > 1 && line[0] != "#")	// Skip blanks and comments
				run_line(line);
		end
		if (fd != 0)
			$fclose(fd);

		$display("Error counts: word %0d, status %0d, data %0d, indicator %0d, other %0d",
			word_errors, status_errors, data_errors, indicator_errors, other_errors);
		if (word_errors + status_errors + data_errors + indicator_errors + other_errors != 0)
			$display("Some tests failed");
		else
			$display("All tests passed");
		$finish;
	end

endmodule

// File: sources.f
source/io_map_pkg.sv
source/uart_pkg.sv
source/uart_transmit.sv
source/uart_receive.sv
source/uart.sv
source/io_registers.sv
source/fpga_io_top.sv
dv/tb_clock.sv
dv/io_tb.sv

// File: Makefile
# Verilator build, run and lint for the board I/O testbench
VERILATOR ?= verilator
TOP ?= io_tb
RTL_TOP ?= fpga_io_top
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter source/%,$(SOURCES))
SIM_BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails on a simulator error or on the fail message in the log
run: $(SIM_BINARY)
	./$(SIM_BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/io_golden.txt
# op address data expected, hex; W write, R read-expect, C check indicators
# X wait for status bits (data = mask), T timer delta (data = cycles), B bad stop-bit frame
# Reset state
C 00 0 0
R 18 0 1
R 40 0 0
R 20 0 0
# Indicator writes, upper write bits get random fill
W 00 2a5c3 0
C 00 0 2a5c3
W 04 1b7 0
C 04 0 1b7
W 08 7f 0
C 08 0 7f
W 0c 55 0
C 0c 0 55
W 10 2a 0
C 10 0 2a
W 14 31 0
C 14 0 31
W 40 ffffffff 0
C 40 0 0
R 40 0 0
W 00 3ffff 0
C 00 0 3ffff
# Timer
T 24 1 1
T 24 a a
T 24 64 64
# Loopback, second write lands while busy and is dropped
W 1c a5 0
W 1c 3c 0
X 18 3 3
T 24 190 190
R 18 0 3
R 1c 0 a5
R 18 0 1
# Overrun
W 1c 5a 0
X 18 3 3
W 1c c3 0
X 18 7 7
R 18 0 7
R 1c 0 c3
R 18 0 1
# Framing error
B 00 81 0
R 18 0 1
C 40 0 0
